//--- sim/alu_deserializer_testdata.txt
# a(hex) b(hex) op crc(0 good,1 flipped) fault(0 none,1 type,2 marker,3 stop,4 glitch) idx
# then idle gap cycles, ack_in delay cycles, outcome (0 ack,1 crc_error,2 frame_error)
12345678 9abcdef0 0 0 0 0 20 5 0
deadbeef 00ff00ff 1 0 0 0 24 12 0
7fffffff 00000001 4 0 0 0 16 0 0
00000010 00000020 5 0 0 0 30 8 0
cafef00d 13579bdf 4 1 0 0 20 6 1
0badc0de 11111111 0 0 1 3 20 4 2
0badc0de 11111111 1 0 1 8 20 4 2
a5a5a5a5 5a5a5a5a 5 0 2 8 20 4 2
01020304 05060708 4 0 3 5 20 4 2
01020304 05060708 4 0 3 8 20 4 2
ffffffff ffffffff 5 0 4 0 40 3 0
00000000 00000000 0 0 0 0 16 1 0
89abcdef 76543210 1 1 0 0 20 10 1
13572468 fedcba98 4 0 0 0 18 2 0

//--- vlog.f
src/deser_pkg.sv
src/bit_sampler.sv
src/frame_receiver.sv
src/packet_checker.sv
src/alu_deserializer.sv
sim/tb_alu_deserializer.sv

//--- Bender.yml
package:
  name: alu_deserializer

sources:
  - src/deser_pkg.sv
  - src/bit_sampler.sv
  - src/frame_receiver.sv
  - src/packet_checker.sv
  - src/alu_deserializer.sv
  - target: test
    files:
      - sim/tb_alu_deserializer.sv

//--- sim/tb_alu_deserializer.sv
`timescale 1ns/1ns
`default_nettype none

module tb_alu_deserializer
    import deser_pkg::*;
();

    localparam int OVERSAMPLE   = 16;
    localparam int FAULT_TYPE   = 1;
    localparam int FAULT_MARKER = 2;
    localparam int FAULT_STOP   = 3;
    localparam int FAULT_GLITCH = 4;

    // One line of the test data file
    typedef struct packed {
        word_t       a;
        word_t       b;
        logic [2:0]  op;
        logic        crc_flip;
        logic [2:0]  fault;
        logic [3:0]  idx;
        logic [15:0] gap;
        logic [15:0] ack_dly;
        logic [1:0]  outcome;
    } test_line_t;

    logic    clk;
    logic    rst;
    logic    serial_in;
    logic    ack_in;
    word_t   data_a;
    word_t   data_b;
    alu_op_t opcode;
    logic    ack;
    logic    frame_error;
    logic    crc_error;

    test_line_t tests[$];
    int         value_errors;
    int         other_errors;
    int         cycle_cnt;
    int         cycle_limit;

    alu_deserializer #(
        .OVERSAMPLE (OVERSAMPLE)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .serial_in   (serial_in),
        .ack_in      (ack_in),
        .data_a      (data_a),
        .data_b      (data_b),
        .opcode      (opcode),
        .ack         (ack),
        .frame_error (frame_error),
        .crc_error   (crc_error)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Run guard
    always @(posedge clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
        begin
            $display("Timeout after %0d cycles, the DUT never gave a result", cycle_cnt);
            other_errors = other_errors + 1;
            $display("Errors: %0d value mismatches, %0d other failures",
                     value_errors, other_errors);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
        begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_op(input string name, input alu_op_t exp, input alu_op_t act);
        if (act !== exp)
        begin
            $display("Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            value_errors++;
        end
    endtask

    ////////////////////
    // Reference CRC
    ////////////////////

    // Remainder of the message times x^4 divided by 10011
    function automatic crc_t crc_by_division(input logic [67:0] msg);
        logic [71:0] rem;
        rem = {msg, 4'b0000};
        for (int i = 71; i >= 4; i--)
        begin
            if (rem[i])
                rem[i -: 5] = rem[i -: 5] ^ 5'b10011;
        end
        return rem[3:0];
    endfunction

    ////////////////////
    // Serial driver
    ////////////////////

    // Inputs move 1 ns after the rising edge
    task automatic wait_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic apply_reset();
        rst       = 1'b0;
        ack_in    = 1'b0;
        serial_in = 1'b1;
        wait_cycles(10);
        rst = 1'b1;
        check_flag("ack", 1'b0, ack);
        check_flag("frame_error", 1'b0, frame_error);
        check_flag("crc_error", 1'b0, crc_error);
    endtask

    task automatic send_frame(input logic type_bit, input byte_t payload, input logic stop_bit);
        logic [9:0] bits;
        bits = {type_bit, payload, stop_bit};
        serial_in = 1'b0;
        wait_cycles(OVERSAMPLE);
        for (int i = 9; i >= 0; i--)
        begin
            serial_in = bits[i];
            wait_cycles(OVERSAMPLE);
        end
        // Up to 3 idle cycles between frames
        serial_in = 1'b1;
        wait_cycles($urandom % 4);
    endtask

    task automatic send_packet(input test_line_t t);
        crc_t  crc;
        byte_t cmd;
        byte_t pl;
        logic  type_bit;
        crc = crc_by_division({t.a, t.b, 1'b1, t.op});
        if (t.crc_flip)
            crc[0] = ~crc[0];
        cmd = {t.fault != FAULT_MARKER, t.op, crc};
        for (int i = 0; i <= DATA_FRAMES; i++)
        begin
            pl       = (i < DATA_FRAMES) ? byte_t'({t.a, t.b} >> (56 - 8 * i)) : cmd;
            type_bit = (i == DATA_FRAMES);
            if (t.fault == FAULT_TYPE && t.idx == i)
                type_bit = ~type_bit;
            send_frame(type_bit, pl, !(t.fault == FAULT_STOP && t.idx == i));
        end
    endtask

    task automatic run_line(input test_line_t t, input int k);
        logic [1:0] expect_out;
        expect_out = (t.fault inside {FAULT_TYPE, FAULT_MARKER, FAULT_STOP}) ? 2'd2 :
                     (t.crc_flip ? 2'd1 : 2'd0);
        if (expect_out != t.outcome)
        begin
            $display("Test data line %0d has an outcome that does not fit its fault", k);
            other_errors++;
        end
        if (t.outcome != 0)
            apply_reset();
        serial_in = 1'b1;
        wait_cycles(t.gap);
        if (t.fault == FAULT_GLITCH)
        begin
            serial_in = 1'b0;
            wait_cycles(4);
            serial_in = 1'b1;
            wait_cycles(t.gap);
        end
        send_packet(t);
        while (!(ack || crc_error || frame_error))
            wait_cycles(1);
        check_flag("ack", t.outcome == 0, ack);
        check_flag("crc_error", t.outcome == 1, crc_error);
        check_flag("frame_error", t.outcome == 2, frame_error);
        if (t.outcome == 0)
        begin
            check_word("data_a", t.a, data_a);
            check_word("data_b", t.b, data_b);
            check_op("opcode", alu_op_t'(t.op), opcode);
            wait_cycles(t.ack_dly);
            check_flag("ack", 1'b1, ack);
            ack_in = 1'b1;
            while (ack)
                wait_cycles(1);
            ack_in = 1'b0;
        end
        else
        begin
            // Error flags are sticky and ack never follows
            wait_cycles(t.ack_dly + 32);
            check_flag("ack", 1'b0, ack);
            check_flag("crc_error", t.outcome == 1, crc_error);
            check_flag("frame_error", t.outcome == 2, frame_error);
            apply_reset();
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial
    begin
        int         fd;
        int         n;
        string      line;
        test_line_t t;
        word_t      fa;
        word_t      fb;
        int         f[7];
        value_errors = 0;
        other_errors = 0;
        cycle_cnt    = 0;
        cycle_limit  = 0;
        rst          = 1'b0;
        serial_in    = 1'b1;
        ack_in       = 1'b0;
        void'($urandom(83));

        fd = $fopen("sim/alu_deserializer_testdata.txt", "r");
        if (fd != 0)
        begin
            while (!$feof(fd))
            begin
                line = "";
                n    = $fgets(line, fd);
                if (line.len() > 0 && line[0] != "#")
                begin
                    n = $sscanf(line, "%h %h %d %d %d %d %d %d %d",
                                fa, fb, f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                    if (n == 9)
                    begin
                        t.a        = fa;
                        t.b        = fb;
                        t.op       = f[0][2:0];
                        t.crc_flip = f[1][0];
                        t.fault    = f[2][2:0];
                        t.idx      = f[3][3:0];
                        t.gap      = f[4][15:0];
                        t.ack_dly  = f[5][15:0];
                        t.outcome  = f[6][1:0];
                        tests.push_back(t);
                    end
                end
            end
            $fclose(fd);
        end
        if (tests.size() == 0)
        begin
            $display("No test lines could be read from the test data file");
            other_errors++;
        end

        // Twice the bare length of all packets
        cycle_limit = tests.size() * 9 * FRAME_BITS * OVERSAMPLE * 2;
        apply_reset();
        foreach (tests[k])
            run_line(tests[k], k);

        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/alu_deserializer.sv
`timescale 1ns/1ns
`default_nettype none

module alu_deserializer
    import deser_pkg::*;
#(
    parameter int OVERSAMPLE = 16
)
(
    input  wire     clk,
    input  wire     rst,
    input  wire     serial_in,
    input  wire     ack_in,
    output word_t   data_a,
    output word_t   data_b,
    output alu_op_t opcode,
    output logic    ack,
    output logic    frame_error,
    output logic    crc_error
);

    logic          frame_valid;
    serial_frame_t frame;
    logic          packet_valid;
    alu_packet_t   packet;

    bit_sampler #(
        .OVERSAMPLE (OVERSAMPLE)
    ) u_bit_sampler (
        .clk         (clk),
        .rst         (rst),
        .serial_in   (serial_in),
        .frame_valid (frame_valid),
        .frame       (frame)
    );

    frame_receiver u_frame_receiver (
        .clk          (clk),
        .rst          (rst),
        .frame_valid  (frame_valid),
        .frame        (frame),
        .packet_valid (packet_valid),
        .packet       (packet),
        .frame_error  (frame_error)
    );

    packet_checker u_packet_checker (
        .clk          (clk),
        .rst          (rst),
        .packet_valid (packet_valid),
        .packet       (packet),
        .ack_in       (ack_in),
        .data_a       (data_a),
        .data_b       (data_b),
        .opcode       (opcode),
        .ack          (ack),
        .crc_error    (crc_error)
    );

endmodule

`default_nettype wire

//--- src/packet_checker.sv
`timescale 1ns/1ns
`default_nettype none

module packet_checker
    import deser_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         packet_valid,
    input  alu_packet_t packet,
    input  wire         ack_in,
    output word_t       data_a,
    output word_t       data_b,
    output alu_op_t     opcode,
    output logic        ack,
    output logic        crc_error
);

    crc_t crc_calc;
    logic crc_ok;

    // A, B, marker and opcode, 68 bits in line order
    assign crc_calc = crc4_d68({packet.data_a, packet.data_b, 1'b1, packet.opcode});
    assign crc_ok   = (crc_calc == packet.crc);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            data_a    <= '0;
            data_b    <= '0;
            opcode    <= OP_AND;
            ack       <= 1'b0;
            crc_error <= 1'b0;
        end
        else if (packet_valid && !crc_error)
        begin
            if (crc_ok)
            begin
                // A newer packet replaces a result still waiting for ack_in
                data_a <= packet.data_a;
                data_b <= packet.data_b;
                opcode <= packet.opcode;
                ack    <= 1'b1;
            end
            else
            begin
                ack       <= 1'b0;
                crc_error <= 1'b1;
            end
        end
        else if (ack_in)
        begin
            ack <= 1'b0;
        end
    end

    assert property (@(posedge clk) disable iff (!rst) !(ack && crc_error));

endmodule

`default_nettype wire

//--- src/frame_receiver.sv
`timescale 1ns/1ns
`default_nettype none

module frame_receiver
    import deser_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire           frame_valid,
    input  serial_frame_t frame,
    output logic          packet_valid,
    output alu_packet_t   packet,
    output logic          frame_error
);

    localparam int CNT_W = $clog2(DATA_FRAMES + 1);

    logic [CNT_W-1:0] frame_cnt;
    logic             is_cmd;
    logic             frame_ok;
    logic             accept;

    // Index DATA_FRAMES is the command frame
    assign is_cmd = (frame_cnt == CNT_W'(DATA_FRAMES));

    ////////////////////
    // Frame checks
    ////////////////////

    always_comb
    begin
        frame_ok = frame.stop_bit;
        if (is_cmd)
        begin
            // Command frames carry the marker bit ahead of the opcode
            frame_ok = frame_ok && frame.type_bit && frame.payload[7];
        end
        else
        begin
            frame_ok = frame_ok && !frame.type_bit;
        end
    end

    // Nothing gets through once the error flag is up
    assign accept = frame_valid && !frame_error && frame_ok;

    ////////////////////
    // Control
    ////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            frame_cnt    <= '0;
            frame_error  <= 1'b0;
            packet_valid <= 1'b0;
        end
        else
        begin
            packet_valid <= 1'b0;
            if (frame_valid && !frame_error)
            begin
                if (!frame_ok)
                begin
                    frame_error <= 1'b1;
                end
                else if (is_cmd)
                begin
                    frame_cnt    <= '0;
                    packet_valid <= 1'b1;
                end
                else
                begin
                    frame_cnt <= frame_cnt + 1'b1;
                end
            end
        end
    end

    ////////////////////
    // Operand and command assembly
    ////////////////////

    // Bytes arrive most significant first, so shift up from the bottom
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            if (is_cmd)
            begin
                packet.opcode <= alu_op_t'(frame.payload[6:4]);
                packet.crc    <= frame.payload[3:0];
            end
            else if (frame_cnt < CNT_W'(A_FRAMES))
            begin
                packet.data_a <= {packet.data_a[23:0], frame.payload};
            end
            else
            begin
                packet.data_b <= {packet.data_b[23:0], frame.payload};
            end
        end
    end

    // A frame error must stay up until the next reset
    assert property (@(posedge clk) disable iff (!rst) frame_error |=> frame_error);

endmodule

`default_nettype wire

//--- src/bit_sampler.sv
`timescale 1ns/1ns
`default_nettype none

module bit_sampler
    import deser_pkg::*;
#(
    parameter int OVERSAMPLE = 16
)
(
    input  wire           clk,
    input  wire           rst,
    input  wire           serial_in,
    output logic          frame_valid,
    output serial_frame_t frame
);

    localparam int CNT_W   = $clog2(OVERSAMPLE);
    localparam int FRAME_W = $bits(serial_frame_t);

    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(OVERSAMPLE / 2 - 1);
    localparam logic [CNT_W-1:0] FULL_LAST = CNT_W'(OVERSAMPLE - 1);

    // Type bit and payload are sampled in BITS, the stop bit in DONE
    localparam logic [3:0] LAST_BIT = 4'(FRAME_BITS - 3);

    sampler_state_t   state;
    logic [CNT_W-1:0] os_cnt;
    logic [3:0]       bit_cnt;
    logic             centre;

    // Bit centre of a data bit, one full period after the previous one
    assign centre = (state == BITS || state == DONE) && (os_cnt == FULL_LAST);

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            state       <= IDLE;
            os_cnt      <= '0;
            bit_cnt     <= '0;
            frame_valid <= 1'b0;
        end
        else
        begin
            frame_valid <= 1'b0;
            if (state == IDLE || centre || (state == START && os_cnt == HALF_LAST))
                os_cnt <= '0;
            else
                os_cnt <= os_cnt + 1'b1;

            case (state)
                IDLE:
                begin
                    bit_cnt <= '0;
                    if (!serial_in)
                        state <= START;
                end
                START:
                begin
                    // Line back high at the centre means a glitch
                    if (os_cnt == HALF_LAST)
                        state <= serial_in ? IDLE : BITS;
                end
                BITS:
                begin
                    if (centre)
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_BIT)
                            state <= DONE;
                    end
                end
                DONE:
                begin
                    if (centre)
                    begin
                        state       <= IDLE;
                        frame_valid <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (centre)
            frame <= {frame[FRAME_W-2:0], serial_in};
    end

    assert property (@(posedge clk) disable iff (!rst) frame_valid |=> !frame_valid);

endmodule

`default_nettype wire

//--- src/deser_pkg.sv
`default_nettype none

package deser_pkg;

    ////////////////////
    // Widths and frame layout
    ////////////////////

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  crc_t;

    // Start + type + 8 payload + stop
    localparam int FRAME_BITS  = 11;
    localparam int DATA_FRAMES = 8;
    localparam int A_FRAMES    = 4;

    // Unlisted codes are carried through as raw values
    typedef enum logic [2:0] {
        OP_AND = 3'b000,
        OP_OR  = 3'b001,
        OP_ADD = 3'b100,
        OP_SUB = 3'b101
    } alu_op_t;

    typedef enum logic [1:0] {
        IDLE,
        START,
        BITS,
        DONE
    } sampler_state_t;

    // Everything after the start bit, first bit on the line in the MSB
    typedef struct packed {
        logic  type_bit;
        byte_t payload;
        logic  stop_bit;
    } serial_frame_t;

    typedef struct packed {
        word_t   data_a;
        word_t   data_b;
        alu_op_t opcode;
        crc_t    crc;
    } alu_packet_t;

    ////////////////////
    // CRC-4, x^4 + x + 1, zero seed, bit 67 enters first
    ////////////////////

    function automatic crc_t crc4_d68(input logic [67:0] data);
        crc_t crc;
        logic fb;
        crc = '0;
        for (int i = 67; i >= 0; i--)
        begin
            fb  = crc[3] ^ data[i];
            crc = {crc[2:0], 1'b0} ^ {2'b00, fb, fb};
        end
        return crc;
    endfunction

endpackage

`default_nettype wire
